// ==== fetch_pkg.sv ====
// fetch stage shared definitions: pc and handler mux encodings, bus and IF/ID structs
package fetch_pkg;

  // --------------------
  // next-pc selection
  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,
    PC_FENCEI    = 4'b0001,
    PC_JUMP      = 4'b0010,  // target from ID
    PC_BRANCH    = 4'b0011,  // target from EX
    PC_EXCEPTION = 4'b0100,
    PC_MRET      = 4'b0101,
    PC_DRET      = 4'b0111
  } pc_mux_e;

  // handler address selection
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,
    EXC_PC_IRQ       = 2'b01,  // vectored interrupt
    EXC_PC_DBD       = 2'b10,  // debug halt
    EXC_PC_DBE       = 2'b11   // exception while in debug
  } exc_pc_mux_e;

  // --------------------
  // instruction bus, req/gnt/rvalid
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } instr_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;     // qualified by rvalid
  } instr_rsp_t;

  // IF/ID payload
  typedef struct packed {
    logic [31:0] instr;       // already expanded
    logic [31:0] pc;
    logic        compressed;
    logic        illegal_c;
    logic        bus_err;
  } if_id_t;

  // base opcodes produced by the RVC expander
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

endpackage

// ==== fetch_fifo.sv ====
// small circular FIFO of fetched words (data plus bus error), single-cycle flush
`timescale 1ns/1ps

module fetch_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         flush_i,
  input  logic                         push_i,
  input  logic [32:0]                  data_i,   // {err, rdata}
  input  logic                         pop_i,
  output logic                         valid_o,
  output logic [32:0]                  data_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [32:0]      mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign do_pop  = pop_i && (count_q != '0);
  assign do_push = push_i && ((count_q != CNT_W'(DEPTH)) || do_pop);  // full but popping is ok

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;  // drop everything, pending push included
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_push && !do_pop) count_q <= count_q + CNT_W'(1);
      else if (do_pop && !do_push) count_q <= count_q - CNT_W'(1);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];  // head word
  assign count_o = count_q;

endmodule

// ==== prefetch_buffer.sv ====
// word prefetcher: issues bus requests, tracks outstanding ones, drops stale responses
`timescale 1ns/1ps

module prefetch_buffer
  import fetch_pkg::*;
#(
  parameter int FIFO_DEPTH = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,          // fetching enabled
  input  logic        branch_i,       // one-cycle redirect
  input  logic [31:0] branch_addr_i,
  input  logic        fetch_ready_i,  // aligner consumed the head word
  output logic        fetch_valid_o,
  output logic [31:0] fetch_rdata_o,
  output logic        fetch_err_o,
  output instr_req_t  instr_req_o,
  input  instr_rsp_t  instr_rsp_i,
  output logic        busy_o
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [31:0]      addr_q;       // next word to request
  logic [31:0]      branch_word;
  logic [CNT_W-1:0] outst_q;      // granted, rvalid not yet seen
  logic [CNT_W-1:0] discard_q;    // stale responses still to drop
  logic [CNT_W-1:0] fifo_cnt;
  logic [CNT_W:0]   fill;
  logic             accept;
  logic             fifo_push;
  logic [32:0]      fifo_rdata;

  assign branch_word = {branch_addr_i[31:2], 2'b00};

  // --------------------
  // request side
  // a flushed FIFO frees its slots in the branch cycle itself
  assign fill = {1'b0, outst_q} + (branch_i ? '0 : {1'b0, fifo_cnt});

  assign instr_req_o.req  = req_i && (fill < (CNT_W+1)'(FIFO_DEPTH));
  assign instr_req_o.addr = branch_i ? branch_word : addr_q;  // redirect even a stalled request
  assign accept           = instr_req_o.req && instr_rsp_i.gnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= accept ? branch_word + 32'd4 : branch_word;
    end else if (accept) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  // --------------------
  // response side
  // responses come back in order, so the stale ones are always the oldest
  assign fifo_push = instr_rsp_i.rvalid && (discard_q == '0) && !branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q   <= '0;
      discard_q <= '0;
    end else begin
      unique case ({accept, instr_rsp_i.rvalid})
        2'b10:   outst_q <= outst_q + CNT_W'(1);
        2'b01:   outst_q <= outst_q - CNT_W'(1);
        default: outst_q <= outst_q;  // none or both
      endcase
      if (branch_i) begin
        // everything in flight belongs to the old path, minus what returns now
        discard_q <= outst_q - CNT_W'(instr_rsp_i.rvalid);
      end else if (instr_rsp_i.rvalid && (discard_q != '0)) begin
        discard_q <= discard_q - CNT_W'(1);
      end
    end
  end

  fetch_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) fetch_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (branch_i),
    .push_i  (fifo_push),
    .data_i  ({instr_rsp_i.err, instr_rsp_i.rdata}),
    .pop_i   (fetch_ready_i),
    .valid_o (fetch_valid_o),
    .data_o  (fifo_rdata),
    .count_o (fifo_cnt)
  );

  assign fetch_rdata_o = fifo_rdata[31:0];
  assign fetch_err_o   = fifo_rdata[32];
  assign busy_o        = (outst_q != '0);

endmodule

// ==== instr_aligner.sv ====
// aligner: cuts 16/32-bit instructions out of the fetched word stream and tracks the PC
`timescale 1ns/1ps

module instr_aligner (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_rdata_i,    // FIFO head word
  input  logic        if_valid_i,       // stage advances this cycle
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,    // bit 0 already cleared
  output logic        aligner_ready_o,  // pop the head word
  output logic        instr_valid_o,
  output logic [31:0] instr_aligned_o,
  output logic [31:0] pc_o
);

  // where the instruction at pc_q starts
  typedef enum logic [1:0] {
    S_ALIGNED,    // low half of head word
    S_HALF_HELD,  // low half sits in residue_q, upper half in head word
    S_UPPER       // upper half of head word, also the branch target case
  } align_state_e;

  align_state_e state_q;
  align_state_e state_d;
  logic [15:0]  residue_q;
  logic [31:0]  pc_q;
  logic [31:0]  pc_step;
  logic         upper_is32;

  assign upper_is32 = (fetch_rdata_i[17:16] == 2'b11);

  // --------------------
  // output select and next state
  always_comb begin
    instr_aligned_o = fetch_rdata_i;
    instr_valid_o   = fetch_valid_i;
    aligner_ready_o = 1'b0;
    state_d         = state_q;
    unique case (state_q)
      S_ALIGNED: begin
        if (fetch_rdata_i[1:0] == 2'b11) begin
          aligner_ready_o = 1'b1;  // whole word used
        end else begin
          state_d = S_UPPER;  // keep word, upper half is next
        end
      end
      S_UPPER: begin
        instr_aligned_o = {16'h0000, fetch_rdata_i[31:16]};
        aligner_ready_o = 1'b1;
        if (upper_is32) begin
          // straddles, park the low half and wait for the next word
          instr_valid_o = 1'b0;
          state_d       = S_HALF_HELD;
        end else begin
          state_d = S_ALIGNED;
        end
      end
      S_HALF_HELD: begin
        instr_aligned_o = {fetch_rdata_i[15:0], residue_q};
        state_d         = S_UPPER;  // same word, no pop
      end
      default: state_d = S_ALIGNED;
    endcase
  end

  assign pc_step = (instr_aligned_o[1:0] == 2'b11) ? 32'd4 : 32'd2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_ALIGNED;
      pc_q    <= '0;
    end else if (branch_i) begin
      pc_q    <= branch_addr_i;
      state_q <= branch_addr_i[1] ? S_UPPER : S_ALIGNED;  // skip lower half on odd target
    end else if (if_valid_i) begin
      state_q <= state_d;
      if (instr_valid_o) pc_q <= pc_q + pc_step;
    end
  end

  // upper half of a straddling instruction's first word
  always_ff @(posedge clk) begin
    if (if_valid_i && (state_q == S_UPPER)) residue_q <= fetch_rdata_i[31:16];
  end

  assign pc_o = pc_q;

endmodule

// ==== compressed_decoder.sv ====
// RVC subset expander, combinational, flags unsupported compressed encodings
`timescale 1ns/1ps

module compressed_decoder
  import fetch_pkg::*;
(
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_instr_o
);

  logic [31:0] raw_half;

  assign raw_half        = {16'h0000, instr_i[15:0]};
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o         = instr_i;  // 32-bit passes unchanged
    illegal_instr_o = 1'b0;
    unique case (instr_i[1:0])
      // --------------------
      // quadrant 0
      2'b00: begin
        unique case (instr_i[15:13])
          3'b010: begin  // c.lw -> lw rd', imm(rs1')
            instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], OPC_LOAD};
          end
          3'b110: begin  // c.sw -> sw rs2', imm(rs1')
            instr_o = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                       2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                       2'b00, OPC_STORE};
          end
          default: begin
            illegal_instr_o = 1'b1;
            instr_o         = raw_half;
          end
        endcase
      end
      // --------------------
      // quadrant 1
      2'b01: begin
        unique case (instr_i[15:13])
          3'b000: begin  // c.addi -> addi rd, rd, imm
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                       3'b000, instr_i[11:7], OPC_OP_IMM};
          end
          3'b010: begin  // c.li -> addi rd, x0, imm
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b0,
                       3'b000, instr_i[11:7], OPC_OP_IMM};
          end
          3'b011: begin
            // rd == x2 is c.addi16sp, not in the subset; zero imm is reserved
            if ((instr_i[11:7] == 5'd2) || ({instr_i[12], instr_i[6:2]} == 6'b0)) begin
              illegal_instr_o = 1'b1;
              instr_o         = raw_half;
            end else begin  // c.lui -> lui rd, imm
              instr_o = {{15{instr_i[12]}}, instr_i[6:2], instr_i[11:7], OPC_LUI};
            end
          end
          3'b101: begin  // c.j -> jal x0, offset
            instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                       instr_i[2], instr_i[11], instr_i[5:3], {9{instr_i[12]}},
                       5'b0, OPC_JAL};
          end
          3'b110: begin  // c.beqz -> beq rs1', x0, offset
            instr_o = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'b0, 2'b01,
                       instr_i[9:7], 3'b000, instr_i[11:10], instr_i[4:3],
                       instr_i[12], OPC_BRANCH};
          end
          default: begin
            illegal_instr_o = 1'b1;
            instr_o         = raw_half;
          end
        endcase
      end
      // --------------------
      // quadrant 2, only c.mv and c.add
      2'b10: begin
        if ((instr_i[15:13] == 3'b100) && (instr_i[6:2] != 5'b0)) begin
          // bit 12 picks c.add (rd + rs2) over c.mv (x0 + rs2)
          instr_o = {7'b0, instr_i[6:2], (instr_i[12] ? instr_i[11:7] : 5'b0),
                     3'b000, instr_i[11:7], OPC_OP};
        end else begin
          illegal_instr_o = 1'b1;  // c.jr, c.jalr, c.ebreak, sp loads etc
          instr_o         = raw_half;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== if_stage.sv ====
// instruction fetch stage: next-pc select, prefetch, align, RVC expand and IF/ID register
`timescale 1ns/1ps

module if_stage
  import fetch_pkg::*;
#(
  parameter int FIFO_DEPTH = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  // fetch targets
  input  logic [31:0] boot_addr_i,
  input  logic [23:0] mtvec_base_i,
  input  logic [4:0]  exc_cause_i,
  input  logic [31:0] dm_halt_addr_i,
  input  logic [31:0] dm_exception_addr_i,
  input  logic [31:0] mepc_i,
  input  logic [31:0] depc_i,
  input  logic [31:0] jump_target_id_i,
  input  logic [31:0] jump_target_ex_i,
  // control strobes from decode
  input  logic        pc_set_i,
  input  pc_mux_e     pc_mux_i,
  input  exc_pc_mux_e exc_pc_mux_i,
  input  logic        clear_instr_valid_i,
  input  logic        halt_if_i,
  input  logic        id_ready_i,
  // instruction bus
  output instr_req_t  instr_req_o,
  input  instr_rsp_t  instr_rsp_i,
  // to decode
  output if_id_t      if_id_o,
  output logic        instr_valid_id_o,
  output logic [31:0] pc_if_o,
  output logic        csr_mtvec_init_o,
  output logic        if_busy_o,
  output logic        perf_imiss_o
);

  logic [31:0] exc_pc;
  logic [31:0] branch_addr_n;
  logic [31:0] branch_addr;   // halfword aligned
  logic        fetch_valid;
  logic [31:0] fetch_rdata;
  logic        fetch_err;
  logic        fetch_ready;
  logic        aligner_ready;
  logic        instr_valid;
  logic [31:0] instr_aligned;
  logic        if_valid;
  logic        prefetch_busy;
  if_id_t      if_id_d;
  if_id_t      if_id_q;
  logic        instr_valid_q;

  // --------------------
  // handler and next-pc muxes
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {mtvec_base_i, 8'h00};                    // base, no offset
      EXC_PC_IRQ:       exc_pc = {mtvec_base_i, 1'b0, exc_cause_i, 2'b00}; // base + 4*cause
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[31:2], 2'b00};
      EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[31:2], 2'b00};
      default:          exc_pc = {mtvec_base_i, 8'h00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT:      branch_addr_n = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:      branch_addr_n = jump_target_id_i;
      PC_BRANCH:    branch_addr_n = jump_target_ex_i;
      PC_EXCEPTION: branch_addr_n = exc_pc;
      PC_MRET:      branch_addr_n = mepc_i;
      PC_DRET:      branch_addr_n = depc_i;
      PC_FENCEI:    branch_addr_n = if_id_q.pc + 32'd4;  // refetch after the fence.i
      default:      branch_addr_n = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  assign branch_addr      = {branch_addr_n[31:1], 1'b0};
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  // --------------------
  // fetch control
  // no advance in the redirect cycle, the head word is from the old path
  assign if_valid    = fetch_valid && id_ready_i && !halt_if_i && !pc_set_i;
  assign fetch_ready = if_valid && aligner_ready;

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) prefetch_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .fetch_err_o   (fetch_err),
    .instr_req_o   (instr_req_o),
    .instr_rsp_i   (instr_rsp_i),
    .busy_o        (prefetch_busy)
  );

  instr_aligner instr_aligner_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_valid_i   (fetch_valid),
    .fetch_rdata_i   (fetch_rdata),
    .if_valid_i      (if_valid),
    .branch_i        (pc_set_i),
    .branch_addr_i   (branch_addr),
    .aligner_ready_o (aligner_ready),
    .instr_valid_o   (instr_valid),
    .instr_aligned_o (instr_aligned),
    .pc_o            (pc_if_o)
  );

  compressed_decoder compressed_decoder_i (
    .instr_i         (instr_aligned),
    .instr_o         (if_id_d.instr),
    .is_compressed_o (if_id_d.compressed),
    .illegal_instr_o (if_id_d.illegal_c)
  );

  assign if_id_d.pc      = pc_if_o;
  assign if_id_d.bus_err = fetch_err;  // carried along, not acted on

  // --------------------
  // IF/ID register, frozen while decode stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
    end else if (if_valid && instr_valid) begin
      instr_valid_q <= 1'b1;
    end else if (clear_instr_valid_i) begin
      instr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid && instr_valid) if_id_q <= if_id_d;
  end

  assign if_id_o          = if_id_q;
  assign instr_valid_id_o = instr_valid_q;
  assign if_busy_o        = prefetch_busy;
  assign perf_imiss_o     = req_i && !fetch_valid && !pc_set_i;  // waiting on memory

endmodule

// ==== tb_instr_mem.sv ====
// instruction memory model: random grant delay, one rvalid per grant one cycle later
`timescale 1ns/1ps

module tb_instr_mem
  import fetch_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h478e
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rand_en_i,  // random grant stalls on
  input  instr_req_t req_i,
  output instr_rsp_t rsp_o
);

  logic [31:0] mem [logic [31:0]];  // sparse image, word addressed by byte address
  int          seed = SEED;
  logic        gnt_ok_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  // words outside the image decode as 32-bit op-imm, upper bits mix the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    fill_word = {addr[31:7] ^ addr[24:0], 7'h13};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] waddr;
    waddr     = {addr[31:2], 2'b00};
    read_word = mem.exists(waddr) ? mem[waddr] : fill_word(waddr);
  endfunction

  // image loading, one halfword at a time
  task automatic store_half(input logic [31:0] addr, input logic [15:0] data);
    logic [31:0] word;
    word = read_word(addr);
    if (addr[1]) word[31:16] = data;
    else word[15:0] = data;
    mem[{addr[31:2], 2'b00}] = word;
  endtask

  // --------------------
  // bus side
  assign rsp_o.gnt    = req_i.req && gnt_ok_q;  // same-cycle grant when not stalling
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_ok_q <= 1'b1;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      gnt_ok_q <= rand_en_i ? (($random(seed) & 3) != 0) : 1'b1;  // about one stall in four
      rvalid_q <= rsp_o.gnt;
      if (rsp_o.gnt) rdata_q <= read_word(req_i.addr);
    end
  end

endmodule

// ==== tb_if_stage.sv ====
// fetch stage testbench with table-driven stream checks under redirects and stalls
`timescale 1ns/1ps

module tb_if_stage
  import fetch_pkg::*;
();

  localparam int          MAX_CYCLES = 4000;  // six tests of at most 400 cycles plus margin
  localparam logic [31:0] SEED       = 32'h478e;
  localparam int          DEPTH      = 2;

  logic        clk;
  logic        rst_n;
  logic        req_i;
  logic [31:0] boot_addr_i;
  logic [23:0] mtvec_base_i;
  logic [4:0]  exc_cause_i;
  logic [31:0] dm_halt_addr_i;
  logic [31:0] dm_exception_addr_i;
  logic [31:0] mepc_i;
  logic [31:0] depc_i;
  logic [31:0] jump_target_id_i;
  logic [31:0] jump_target_ex_i;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  exc_pc_mux_e exc_pc_mux_i;
  logic        clear_instr_valid_i;
  logic        halt_if_i;
  logic        id_ready_i;
  instr_req_t  instr_req_o;
  instr_rsp_t  instr_rsp_i;
  if_id_t      if_id_o;
  logic        instr_valid_id_o;
  logic [31:0] pc_if_o;
  logic        csr_mtvec_init_o;
  logic        if_busy_o;
  logic        perf_imiss_o;
  logic        rand_en;

  // expected stream keyed by halfword address
  logic [31:0] tab_instr [logic [31:0]];
  logic        tab_c     [logic [31:0]];
  logic        tab_ill   [logic [31:0]];
  logic [31:0] exp_pc;
  logic [31:0] last_pc;
  if_id_t      prev_if_id;
  logic        hold_prev = 1'b0;
  logic        seen_req  = 1'b0;
  logic        exp_mtvec_init = 1'b0;
  int          xfer_cnt  = 0;
  int          err_cnt   = 0;
  int          err_mark  = 0;
  int          fail_tests = 0;
  int          cycle_cnt = 0;
  int          seed      = SEED;

  if_stage #(.FIFO_DEPTH (DEPTH)) dut_i (.*);

  tb_instr_mem #(.SEED (SEED)) mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rand_en_i (rand_en),
    .req_i     (instr_req_o),
    .rsp_o     (instr_rsp_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // checks
  task automatic check_val(input string name, input logic [66:0] exp, input logic [66:0] act);
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("t=%0t check broken: %s", $time, what);
      err_cnt++;
    end
  endtask

  // compare one transfer into decode against the table or the memory fill word
  task automatic check_transfer();
    logic [31:0] e_instr;
    logic        e_c;
    logic        e_ill;
    if (tab_instr.exists(exp_pc)) begin
      e_instr = tab_instr[exp_pc];
      e_c     = tab_c[exp_pc];
      e_ill   = tab_ill[exp_pc];
    end else begin
      e_instr = mem_i.fill_word(exp_pc);
      e_c     = 1'b0;
      e_ill   = 1'b0;
    end
    check_val("if_id_o.pc", exp_pc, if_id_o.pc);
    check_val("if_id_o.instr", e_instr, if_id_o.instr);
    check_val("if_id_o.compressed", e_c, if_id_o.compressed);
    check_val("if_id_o.illegal_c", e_ill, if_id_o.illegal_c);
    check_val("if_id_o.bus_err", 1'b0, if_id_o.bus_err);
    last_pc = exp_pc;
    exp_pc  = exp_pc + (e_c ? 32'd2 : 32'd4);
    check_val("pc_if_o", exp_pc, pc_if_o);  // aligner already points at the next one
    xfer_cnt++;
  endtask

  // per-cycle checks on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (!seen_req && instr_req_o.req) begin
        seen_req = 1'b1;
        check_val("instr_req_o.addr", {boot_addr_i[31:2], 2'b00}, instr_req_o.addr);
        check_true(pc_set_i, "first request issued outside the boot redirect cycle");
      end
      check_val("csr_mtvec_init_o", exp_mtvec_init, csr_mtvec_init_o);
      if (hold_prev) check_val("if_id_o", prev_if_id, if_id_o);  // frozen while stalled
      if (instr_valid_id_o && id_ready_i) check_transfer();
      hold_prev  = !id_ready_i || halt_if_i;
      prev_if_id = if_id_o;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // stimulus helpers called right after a rising edge
  task automatic add_entry(input logic [31:0] addr, input logic [31:0] raw,
                           input logic [31:0] expanded, input logic ill);
    tab_instr[addr] = expanded;
    tab_c[addr]     = (raw[1:0] != 2'b11);
    tab_ill[addr]   = ill;
    mem_i.store_half(addr, raw[15:0]);
    if (raw[1:0] == 2'b11) mem_i.store_half(addr + 32'd2, raw[31:16]);
  endtask

  task automatic redirect(input pc_mux_e mux, input exc_pc_mux_e exc, input logic [31:0] target);
    pc_set_i       <= 1'b1;
    pc_mux_i       <= mux;
    exc_pc_mux_i   <= exc;
    exp_mtvec_init = (mux == PC_BOOT);  // csr init pulses only on the boot redirect
    @(posedge clk);
    pc_set_i <= 1'b0;
    exp_mtvec_init = 1'b0;
    exp_pc   = target;  // anything older is now off the path
  endtask

  task automatic wait_xfers(input int n);
    int target;
    target = xfer_cnt + n;
    while (xfer_cnt < target) @(posedge clk);
  endtask

  task automatic set_ready(input logic rdy);
    id_ready_i          <= rdy;
    clear_instr_valid_i <= rdy;  // decode clears once it takes the instruction
  endtask

  task automatic end_test(input int num, input string name);
    if (err_cnt == err_mark) begin
      $display("test %0d %s: ok, %0d transfers so far", num, name, xfer_cnt);
    end else begin
      $display("test %0d %s: %0d errors", num, name, err_cnt - err_mark);
      fail_tests++;
    end
    err_mark = err_cnt;
  endtask

  // --------------------
  // tests
  initial begin
    int stall;
    rst_n = 1'b0;
    req_i = 1'b0;
    boot_addr_i = 32'h0000_0082;  // low bits dropped on boot
    mtvec_base_i = 24'h000100;
    exc_cause_i = 5'd11;
    dm_halt_addr_i = 32'h0002_0803;
    dm_exception_addr_i = 32'h0002_0906;
    mepc_i = 32'h0000_0088;
    depc_i = 32'h0000_008e;
    jump_target_id_i = '0;
    jump_target_ex_i = '0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXCEPTION;
    clear_instr_valid_i = 1'b1;
    halt_if_i = 1'b0;
    id_ready_i = 1'b1;
    rand_en = 1'b0;
    exp_pc = '0;
    last_pc = '0;

    // mixed stream from 0x80 up to the word at 0xa0
    add_entry(32'h80, 32'h4515, 32'h00500513, 1'b0);          // c.li a0, 5
    add_entry(32'h82, 32'h00150593, 32'h00150593, 1'b0);      // addi a1, a0, 1 straddles
    add_entry(32'h86, 32'h157d, 32'hfff50513, 1'b0);          // c.addi a0, -1
    add_entry(32'h88, 32'h00b50633, 32'h00b50633, 1'b0);      // add a2, a0, a1
    add_entry(32'h8c, 32'h86b2, 32'h00c006b3, 1'b0);          // c.mv a3, a2
    add_entry(32'h8e, 32'h8082, 32'h00008082, 1'b1);          // c.jr ra is outside the subset
    add_entry(32'h90, 32'h4044, 32'h00442483, 1'b0);          // c.lw s1, 4(s0)
    add_entry(32'h92, 32'h123452b7, 32'h123452b7, 1'b0);      // lui t0 straddles
    add_entry(32'h96, 32'hc404, 32'h00942423, 1'b0);          // c.sw s1, 8(s0)
    add_entry(32'h98, 32'h7ff00093, 32'h7ff00093, 1'b0);
    add_entry(32'h9c, 32'h6785, 32'h000017b7, 1'b0);          // c.lui a5, 1
    add_entry(32'h9e, 32'h0405, 32'h00140413, 1'b0);          // c.addi s0, 1

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("instr_req_o.req", 1'b0, instr_req_o.req);
    check_val("instr_valid_id_o", 1'b0, instr_valid_id_o);
    check_val("if_busy_o", 1'b0, if_busy_o);
    check_val("csr_mtvec_init_o", 1'b0, csr_mtvec_init_o);
    check_val("perf_imiss_o", 1'b0, perf_imiss_o);
    @(posedge clk);

    req_i <= 1'b1;
    redirect(PC_BOOT, EXC_PC_EXCEPTION, {boot_addr_i[31:2], 2'b00});
    wait_xfers(1);
    end_test(1, "boot");

    wait_xfers(15);  // rest of the table and into fill words
    end_test(2, "mixed stream");

    jump_target_id_i <= 32'h86;  // upper half of a word
    redirect(PC_JUMP, EXC_PC_EXCEPTION, 32'h86);
    wait_xfers(4);
    jump_target_ex_i <= 32'h92;  // straddler in the upper half
    redirect(PC_BRANCH, EXC_PC_EXCEPTION, 32'h92);
    wait_xfers(4);
    end_test(3, "jump and branch");

    redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, {mtvec_base_i, 8'h00});
    wait_xfers(3);
    redirect(PC_EXCEPTION, EXC_PC_IRQ, {mtvec_base_i, 8'h00} + 32'(exc_cause_i) * 32'd4);
    wait_xfers(3);
    redirect(PC_EXCEPTION, EXC_PC_DBD, {dm_halt_addr_i[31:2], 2'b00});
    wait_xfers(3);
    redirect(PC_EXCEPTION, EXC_PC_DBE, {dm_exception_addr_i[31:2], 2'b00});
    wait_xfers(3);
    redirect(PC_MRET, EXC_PC_EXCEPTION, mepc_i);
    wait_xfers(3);
    redirect(PC_DRET, EXC_PC_EXCEPTION, depc_i);
    wait_xfers(3);
    end_test(4, "vectors");

    rand_en          <= 1'b1;
    jump_target_id_i <= 32'h80;
    redirect(PC_JUMP, EXC_PC_EXCEPTION, 32'h80);
    for (int i = 0; i < 4; i++) begin
      wait_xfers(2);
      stall = 2 + ($unsigned($random(seed)) % 4);
      set_ready(1'b0);
      repeat (stall) @(posedge clk);
      set_ready(1'b1);
      wait_xfers(2);
      stall = 2 + ($unsigned($random(seed)) % 4);
      halt_if_i <= 1'b1;
      repeat (stall) @(posedge clk);
      halt_if_i <= 1'b0;
    end
    wait_xfers(2);
    rand_en <= 1'b0;
    end_test(5, "stall");

    wait_xfers(3);
    halt_if_i <= 1'b1;  // decode keeps clearing while nothing new arrives
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_val("instr_valid_id_o", 1'b0, instr_valid_id_o);
    @(posedge clk);
    redirect(PC_FENCEI, EXC_PC_EXCEPTION, last_pc + 32'd4);
    halt_if_i <= 1'b0;
    wait_xfers(4);
    end_test(6, "clear and fence.i");

    $display("summary: 6 tests, %0d with errors, %0d errors, %0d transfers",
             fail_tests, err_cnt, xfer_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
fetch_pkg.sv
fetch_fifo.sv
prefetch_buffer.sv
instr_aligner.sv
compressed_decoder.sv
if_stage.sv
tb_instr_mem.sv
tb_if_stage.sv

// ==== Bender.yml ====
package:
  name: if_stage

sources:
  - fetch_pkg.sv
  - fetch_fifo.sv
  - prefetch_buffer.sv
  - instr_aligner.sv
  - compressed_decoder.sv
  - if_stage.sv
  - target: test
    files:
      - tb_instr_mem.sv
      - tb_if_stage.sv
